/* verilog/igr_seg_pkg.sv */
// shared types and constants for the ingress segment builder, imported by every RTL block
package igr_seg_pkg;

  // one 64-bit data word with its 8-bit check byte in the upper bits
  typedef logic [71:0] data72_t;

  // port timestamp carried with the start of packet
  typedef logic [15:0] seg_ts_t;

  // lane source select, 0 to 7 pick an input lane and 8 picks the pad word
  typedef logic [3:0] lane_sel_t;

  // one select per segment lane
  typedef lane_sel_t [0:7] seg_sel_t;

  // number of valid words in a beat, 0 means idle
  typedef logic [3:0] beat_cnt_t;

  // per-segment metadata handed to the packet buffer
  typedef struct packed {
    logic       sop;
    logic       eop;
    logic [2:0] eop_pos;  // last valid lane when eop is set
    logic [1:0] error;
    logic [2:0] tc;
    logic       partial;  // eop left padded lanes behind it
  } seg_md_t;

  typedef struct packed {
    seg_md_t md;
    seg_ts_t ts;
  } seg_ts_md_t;

  // unused lanes are filled with zero data and check byte 6
  localparam data72_t pad_word = {8'h06, 64'h0};

  // packet tracking in the controller
  typedef enum logic [1:0] {
    st_idle,
    st_fill,
    st_drain
  } fill_state_t;

endpackage

/* verilog/seg_wr_if.sv */
// write controls from the packing controller to one segment bank, one instance per bank
`timescale 1ns/10ps

interface seg_wr_if;
  import igr_seg_pkg::*;

  // per-lane source select, only looked at where we is set
  seg_sel_t   sel;
  // per-lane load enable
  logic [7:0] we;
  // first word of a packet lands in this bank, capture the sop fields
  logic       sop_e;
  // the bank holds a finished segment after this edge
  logic       seg_e;
  // metadata of the beat, eop_pos already resolved for this bank
  seg_md_t    md;

  // the controller owns every field
  modport ctrl (
    output sel,
    output we,
    output sop_e,
    output seg_e,
    output md
  );

  modport bank (
    input sel,
    input we,
    input sop_e,
    input seg_e,
    input md
  );

endinterface

/* verilog/seg_pack_ctrl.sv */
// packing controller, maps beat words onto the ping-pong banks and flags finished segments
`timescale 1ns/10ps

module seg_pack_ctrl (
  input  logic                  cclk,
  input  logic                  rst,
  input  igr_seg_pkg::beat_cnt_t i_rx_cnt,
  input  logic                  i_rx_sop,
  input  logic                  i_rx_eop,
  input  logic [1:0]            i_rx_err,
  input  logic [2:0]            i_rx_tc,
  seg_wr_if.ctrl                o_bank0,
  seg_wr_if.ctrl                o_bank1,
  output logic [1:0]            o_done
);
  import igr_seg_pkg::*;

  logic [2:0]  ptr;
  logic        act;
  fill_state_t state;

  logic        acc;
  logic        eop_beat;
  logic        spill;
  beat_cnt_t   eff_cnt;
  logic [4:0]  tot;

  seg_sel_t    cur_sel;
  seg_sel_t    nxt_sel;
  logic [7:0]  cur_we;
  logic [7:0]  nxt_we;
  logic        cur_seg_e;
  logic        nxt_seg_e;
  seg_md_t     cur_md;
  seg_md_t     nxt_md;

  // --------------------------------------------------------------------------
  // beat qualification
  // --------------------------------------------------------------------------

  // words outside a packet are dropped, a packet opens only with sop
  assign acc      = (i_rx_cnt != 4'd0) && ((state == st_fill) || i_rx_sop);
  assign eff_cnt  = acc ? i_rx_cnt : 4'd0;
  assign eop_beat = acc && i_rx_eop;

  // one past the last lane written, above 8 means the beat runs into the other bank
  assign tot   = {2'b00, ptr} + {1'b0, eff_cnt};
  assign spill = (tot > 5'd8);

  // the active bank closes when it fills up or the packet ends in it
  assign cur_seg_e = acc && (i_rx_eop || (tot >= 5'd8));
  // the other bank closes only when the packet ends inside the spill
  assign nxt_seg_e = eop_beat && spill;

  // --------------------------------------------------------------------------
  // lane mapping
  // --------------------------------------------------------------------------

  always_comb begin
    for (int l = 0; l < 8; l++) begin
      cur_sel[l] = 4'd8;
      nxt_sel[l] = 4'd8;
      cur_we[l]  = 1'b0;
      nxt_we[l]  = 1'b0;
      // word k of the beat goes to lane ptr+k of the active bank
      if ((5'(l) >= {2'b00, ptr}) && (5'(l) < tot)) begin
        cur_sel[l] = 4'(5'(l) - {2'b00, ptr});
        cur_we[l]  = 1'b1;
      end else if (eop_beat && (5'(l) >= tot)) begin
        // lanes after the last word are padded, select stays on the pad word
        cur_we[l]  = 1'b1;
      end
      // overflow continues from lane 0 of the other bank
      if ((5'(l) + 5'd8) < tot) begin
        nxt_sel[l] = 4'(5'(l) + 5'd8 - {2'b00, ptr});
        nxt_we[l]  = 1'b1;
      end else if (nxt_seg_e) begin
        nxt_we[l]  = 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // metadata
  // --------------------------------------------------------------------------

  // on a spill the active bank is full and the end lands in the other bank
  always_comb begin
    cur_md.sop     = i_rx_sop;
    cur_md.eop     = eop_beat && !spill;
    cur_md.eop_pos = cur_md.eop ? 3'(tot - 5'd1) : 3'd7;
    cur_md.error   = i_rx_err;
    cur_md.tc      = i_rx_tc;
    cur_md.partial = cur_md.eop && (tot[2:0] != 3'd0);
    // sop always starts at lane 0 of the active bank so the spill never carries it
    nxt_md         = cur_md;
    nxt_md.sop     = 1'b0;
    nxt_md.eop     = 1'b1;
    // tot-1 also gives the last lane of the spill since the spill offset is 8
    nxt_md.eop_pos = 3'(tot - 5'd1);
    nxt_md.partial = (tot[2:0] != 3'd0);
  end

  // route the active and spill views onto the two physical banks
  assign o_bank0.sel   = act ? nxt_sel : cur_sel;
  assign o_bank0.we    = act ? nxt_we : cur_we;
  assign o_bank0.sop_e = !act && acc && i_rx_sop;
  assign o_bank0.seg_e = act ? nxt_seg_e : cur_seg_e;
  assign o_bank0.md    = act ? nxt_md : cur_md;

  assign o_bank1.sel   = act ? cur_sel : nxt_sel;
  assign o_bank1.we    = act ? cur_we : nxt_we;
  assign o_bank1.sop_e = act && acc && i_rx_sop;
  assign o_bank1.seg_e = act ? cur_seg_e : nxt_seg_e;
  assign o_bank1.md    = act ? cur_md : nxt_md;

  // --------------------------------------------------------------------------
  // fill pointer, active bank and packet state
  // --------------------------------------------------------------------------

  always_ff @(posedge cclk) begin
    if (rst) begin
      ptr    <= 3'd0;
      act    <= 1'b0;
      state  <= st_idle;
      o_done <= 2'b00;
    end else begin
      // the banks hold the finished segment one edge after seg_e
      o_done <= {o_bank1.seg_e, o_bank0.seg_e};
      if (acc) begin
        if (i_rx_eop) begin
          // a double completion closes both banks so the active one is fresh again
          ptr   <= 3'd0;
          act   <= spill ? act : !act;
          state <= st_drain;
        end else begin
          // low bits already hold the spill count once the bank is full
          ptr   <= tot[2:0];
          act   <= (tot >= 5'd8) ? !act : act;
          state <= st_fill;
        end
      end else if (state == st_drain) begin
        state <= st_idle;
      end
    end
  end

  a_cnt_range: assert property (@(posedge cclk) disable iff (rst)
    i_rx_cnt <= 4'd8)
    else $error("beat count above 8");

  // the idle beat lets a double completion leave seg_out before the next one
  a_eop_idle: assert property (@(posedge cclk) disable iff (rst)
    ((i_rx_cnt != 4'd0) && i_rx_eop) |=> (i_rx_cnt == 4'd0))
    else $error("eop beat not followed by an idle beat");

endmodule

/* verilog/shim_seg.sv */
// one 64-byte segment bank, lane muxes and registers plus sop metadata capture
`timescale 1ns/10ps

module shim_seg (
  input  logic                       cclk,
  input  logic                       rst,
  input  igr_seg_pkg::data72_t [0:7] i_rx_data,
  input  igr_seg_pkg::seg_ts_t       i_rx_ts,
  seg_wr_if.bank                     i_wr,
  output igr_seg_pkg::data72_t [0:7] o_seg_data,
  output igr_seg_pkg::seg_ts_md_t    o_seg_ts_md
);
  import igr_seg_pkg::*;

  data72_t [0:7] seg_q;
  seg_ts_md_t    ts_md_q;

  // sop fields held until the segment that carries the sop completes
  logic          cap_sop;
  logic [1:0]    cap_err;
  logic [2:0]    cap_tc;
  seg_ts_t       cap_ts;

  assign o_seg_data  = seg_q;
  assign o_seg_ts_md = ts_md_q;

  // --------------------------------------------------------------------------
  // lane datapath
  // --------------------------------------------------------------------------

  for (genvar l = 0; l < 8; l++) begin : g_lane
    data72_t lane_d;

    // selects 0 to 7 take an input word, anything else is padding
    always_comb begin
      if (i_wr.sel[l] < 4'd8) begin
        lane_d = i_rx_data[i_wr.sel[l][2:0]];
      end else begin
        lane_d = pad_word;
      end
    end

    // the bank comes out of reset as an all-pad segment
    always_ff @(posedge cclk) begin
      if (rst) begin
        seg_q[l] <= pad_word;
      end else if (i_wr.we[l]) begin
        seg_q[l] <= lane_d;
      end
    end

    a_sel_legal: assert property (@(posedge cclk) disable iff (rst)
      i_wr.we[l] |-> (i_wr.sel[l] <= 4'd8))
      else $error("lane %0d written with select above 8", l);
  end

  // --------------------------------------------------------------------------
  // metadata
  // --------------------------------------------------------------------------

  // a packet may open in a bank that completes on a later beat, so the
  // start fields wait here, a completion on the same beat takes them direct
  always_ff @(posedge cclk) begin
    if (rst || i_wr.seg_e) begin
      cap_sop <= 1'b0;
      cap_err <= 2'b00;
      cap_tc  <= 3'd0;
      cap_ts  <= '0;
    end else if (i_wr.sop_e) begin
      cap_sop <= i_wr.md.sop;
      cap_err <= i_wr.md.error;
      cap_tc  <= i_wr.md.tc;
      cap_ts  <= i_rx_ts;
    end
  end

  // end fields come from the completing beat, errors of both beats accumulate
  always_ff @(posedge cclk) begin
    if (rst) begin
      ts_md_q <= '0;
    end else if (i_wr.seg_e) begin
      ts_md_q.md.sop     <= cap_sop ? cap_sop : i_wr.md.sop;
      ts_md_q.md.eop     <= i_wr.md.eop;
      ts_md_q.md.eop_pos <= i_wr.md.eop_pos;
      ts_md_q.md.error   <= cap_err | i_wr.md.error;
      ts_md_q.md.tc      <= cap_sop ? cap_tc : i_wr.md.tc;
      ts_md_q.md.partial <= i_wr.md.partial;
      ts_md_q.ts         <= cap_sop ? cap_ts : i_rx_ts;
    end
  end

endmodule

/* verilog/seg_out.sv */
// output stage, registers finished segments in bank order with one pending slot
`timescale 1ns/10ps

module seg_out (
  input  logic                       cclk,
  input  logic                       rst,
  input  logic [1:0]                 i_done,
  input  igr_seg_pkg::data72_t [0:7] i_seg0_data,
  input  igr_seg_pkg::data72_t [0:7] i_seg1_data,
  input  igr_seg_pkg::seg_ts_md_t    i_seg0_ts_md,
  input  igr_seg_pkg::seg_ts_md_t    i_seg1_ts_md,
  output logic                       o_seg_valid,
  output igr_seg_pkg::data72_t [0:7] o_seg_data,
  output igr_seg_pkg::seg_ts_md_t    o_seg_ts_md
);
  import igr_seg_pkg::*;

  data72_t [0:7] pend_data;
  seg_ts_md_t    pend_ts_md;
  logic          pend_v;
  logic          last_bank;
  logic          first_bank;

  // completions alternate between banks, so the older of two is the one
  // after the bank emitted last
  assign first_bank = !last_bank;

  always_ff @(posedge cclk) begin
    if (rst) begin
      o_seg_valid <= 1'b0;
      pend_v      <= 1'b0;
      // bank 0 completes first after reset
      last_bank   <= 1'b1;
    end else begin
      o_seg_valid <= pend_v || (i_done != 2'b00);
      pend_v      <= &i_done;
      // on a pair the pending bank ends up last, which is the current value
      if (!pend_v && (i_done[0] ^ i_done[1])) begin
        last_bank <= i_done[1];
      end
    end
  end

  // the bank may refill right after completion, copy both banks at once
  always_ff @(posedge cclk) begin
    if (pend_v) begin
      o_seg_data  <= pend_data;
      o_seg_ts_md <= pend_ts_md;
    end else if (&i_done) begin
      o_seg_data  <= first_bank ? i_seg1_data : i_seg0_data;
      o_seg_ts_md <= first_bank ? i_seg1_ts_md : i_seg0_ts_md;
      pend_data   <= first_bank ? i_seg0_data : i_seg1_data;
      pend_ts_md  <= first_bank ? i_seg0_ts_md : i_seg1_ts_md;
    end else if (i_done[1]) begin
      o_seg_data  <= i_seg1_data;
      o_seg_ts_md <= i_seg1_ts_md;
    end else if (i_done[0]) begin
      o_seg_data  <= i_seg0_data;
      o_seg_ts_md <= i_seg0_ts_md;
    end
  end

  // relies on the idle beat after eop upstream, nothing can finish while a pair drains
  a_pend_free: assert property (@(posedge cclk) disable iff (rst)
    pend_v |-> (i_done == 2'b00))
    else $error("segment completed while the pending slot was busy");

endmodule

/* verilog/igr_seg_top.sv */
// ingress segment builder top, packs port beats into aligned 64-byte segments with metadata
`timescale 1ns/10ps

module igr_seg_top (
  input  logic                       cclk,
  input  logic                       rst,
  input  igr_seg_pkg::data72_t [0:7] i_rx_data,
  input  igr_seg_pkg::beat_cnt_t     i_rx_cnt,
  input  logic                       i_rx_sop,
  input  logic                       i_rx_eop,
  input  logic [1:0]                 i_rx_err,
  input  logic [2:0]                 i_rx_tc,
  input  igr_seg_pkg::seg_ts_t       i_rx_ts,
  output logic                       o_seg_valid,
  output igr_seg_pkg::data72_t [0:7] o_seg_data,
  output igr_seg_pkg::seg_ts_md_t    o_seg_ts_md
);
  import igr_seg_pkg::*;

  // write controls for each bank
  seg_wr_if bank0_wr ();
  seg_wr_if bank1_wr ();

  logic [1:0]    done;
  data72_t [0:7] seg0_data;
  data72_t [0:7] seg1_data;
  seg_ts_md_t    seg0_ts_md;
  seg_ts_md_t    seg1_ts_md;

  seg_pack_ctrl seg_pack_ctrl_i (
    .cclk     (cclk),
    .rst      (rst),
    .i_rx_cnt (i_rx_cnt),
    .i_rx_sop (i_rx_sop),
    .i_rx_eop (i_rx_eop),
    .i_rx_err (i_rx_err),
    .i_rx_tc  (i_rx_tc),
    .o_bank0  (bank0_wr),
    .o_bank1  (bank1_wr),
    .o_done   (done)
  );

  // beat data and timestamp fan out to both banks
  shim_seg shim_seg0_i (
    .cclk        (cclk),
    .rst         (rst),
    .i_rx_data   (i_rx_data),
    .i_rx_ts     (i_rx_ts),
    .i_wr        (bank0_wr),
    .o_seg_data  (seg0_data),
    .o_seg_ts_md (seg0_ts_md)
  );

  shim_seg shim_seg1_i (
    .cclk        (cclk),
    .rst         (rst),
    .i_rx_data   (i_rx_data),
    .i_rx_ts     (i_rx_ts),
    .i_wr        (bank1_wr),
    .o_seg_data  (seg1_data),
    .o_seg_ts_md (seg1_ts_md)
  );

  seg_out seg_out_i (
    .cclk         (cclk),
    .rst          (rst),
    .i_done       (done),
    .i_seg0_data  (seg0_data),
    .i_seg1_data  (seg1_data),
    .i_seg0_ts_md (seg0_ts_md),
    .i_seg1_ts_md (seg1_ts_md),
    .o_seg_valid  (o_seg_valid),
    .o_seg_data   (o_seg_data),
    .o_seg_ts_md  (o_seg_ts_md)
  );

endmodule

/* test/tb_igr_seg.sv */
// testbench for the segment builder, replays beats from test/seg_input.txt and checks each segment
`timescale 1ns/10ps

module tb_igr_seg;
  import igr_seg_pkg::*;

  // pad lanes carry zero data and check byte 6
  localparam data72_t pad_exp = {8'h06, 64'h0};
  localparam int seg_timeout = 20;

  logic          cclk;
  logic          rst;
  data72_t [0:7] i_rx_data;
  logic [3:0]    i_rx_cnt;
  logic          i_rx_sop;
  logic          i_rx_eop;
  logic [1:0]    i_rx_err;
  logic [2:0]    i_rx_tc;
  logic [15:0]   i_rx_ts;
  logic          o_seg_valid;
  data72_t [0:7] o_seg_data;
  seg_ts_md_t    o_seg_ts_md;

  // segments seen on the output, in arrival order
  data72_t [0:7]    rx_data_q[$];
  seg_ts_md_t       rx_md_q[$];
  int               fd;
  int               test_errs;
  int               pass_cnt;
  int               fail_cnt;
  bit               aborted;
  logic [8*24-1:0]  test_name;

  igr_seg_top igr_seg_top_i (
    .cclk        (cclk),
    .rst         (rst),
    .i_rx_data   (i_rx_data),
    .i_rx_cnt    (i_rx_cnt),
    .i_rx_sop    (i_rx_sop),
    .i_rx_eop    (i_rx_eop),
    .i_rx_err    (i_rx_err),
    .i_rx_tc     (i_rx_tc),
    .i_rx_ts     (i_rx_ts),
    .o_seg_valid (o_seg_valid),
    .o_seg_data  (o_seg_data),
    .o_seg_ts_md (o_seg_ts_md)
  );

  initial begin
    cclk = 1'b0;
    forever #5 cclk = ~cclk;
  end

  // the output is registered on the rising edge, so the falling edge sees it settled
  always @(negedge cclk) begin
    if (o_seg_valid) begin
      rx_data_q.push_back(o_seg_data);
      rx_md_q.push_back(o_seg_ts_md);
    end
  end

  // --------------------------------------------------------------------------
  // stimulus and checking helpers
  // --------------------------------------------------------------------------

  task automatic drive_idle(input int n);
    repeat (n) begin
      @(posedge cclk);
      i_rx_cnt <= 4'd0;
    end
  endtask

  // every lane gets base+k, lanes past the count must never reach a segment
  task automatic drive_beat(input logic [3:0] cnt, input logic sop, input logic eop,
                            input logic [1:0] err, input logic [2:0] tc,
                            input logic [15:0] ts, input logic [63:0] base);
    logic [63:0] val;
    int          k;
    @(posedge cclk);
    for (k = 0; k < 8; k++) begin
      val = base + 64'(k);
      i_rx_data[k] <= {val[7:0], val};
    end
    i_rx_cnt <= cnt;
    i_rx_sop <= sop;
    i_rx_eop <= eop;
    i_rx_err <= err;
    i_rx_tc  <= tc;
    i_rx_ts  <= ts;
  endtask

  // the input goes idle while the testbench waits for the output
  task automatic wait_segment(output bit got);
    int n;
    n = 0;
    while ((rx_md_q.size() == 0) && (n < seg_timeout)) begin
      @(posedge cclk);
      i_rx_cnt <= 4'd0;
      n++;
    end
    got = (rx_md_q.size() != 0);
  endtask

  task automatic check_field(input string field, input logic [71:0] exp_v,
                             input logic [71:0] act_v);
    assert (act_v == exp_v) else begin
      $display("Mismatch %0s %0s: expected %0h actual %0h", test_name, field, exp_v, act_v);
      test_errs++;
    end
  endtask

  // lanes hold consecutive words from the first one, the last pad lanes hold padding
  task automatic check_segment(input logic [63:0] first, input logic [2:0] pos,
                               input logic sop, input logic eop, input logic [1:0] err,
                               input logic [2:0] tc, input logic [15:0] ts,
                               input logic [3:0] pad);
    data72_t [0:7] got_data;
    seg_ts_md_t    got;
    data72_t       exp_word;
    logic [63:0]   val;
    int            l;
    got_data = rx_data_q.pop_front();
    got      = rx_md_q.pop_front();
    for (l = 0; l < 8; l++) begin
      val = first + 64'(l);
      if (l < (8 - int'(pad))) begin
        exp_word = {val[7:0], val};
      end else begin
        exp_word = pad_exp;
      end
      check_field($sformatf("lane %0d", l), exp_word, got_data[l]);
    end
    check_field("sop", 72'(sop), 72'(got.md.sop));
    check_field("eop", 72'(eop), 72'(got.md.eop));
    // a full segment ends at lane 7
    check_field("eop_pos", 72'(pos), 72'(got.md.eop_pos));
    // only the segment that ends the packet can have padded lanes
    check_field("partial", 72'(eop && (pad != 4'd0)), 72'(got.md.partial));
    check_field("error", 72'(err), 72'(got.md.error));
    check_field("tc", 72'(tc), 72'(got.md.tc));
    check_field("ts", 72'(ts), 72'(got.ts));
  endtask

  task automatic end_test();
    drive_idle(4);
    assert (rx_md_q.size() == 0) else begin
      $display("%0s: %0d segments arrived that no expected line covers", test_name,
               rx_md_q.size());
      test_errs++;
      rx_md_q.delete();
      rx_data_q.delete();
    end
    if (test_errs == 0) begin
      pass_cnt++;
      $display("%0s: PASS", test_name);
    end else begin
      fail_cnt++;
      $display("%0s: FAIL with %0d errors", test_name, test_errs);
    end
  endtask

  // --------------------------------------------------------------------------
  // file replay
  // --------------------------------------------------------------------------

  task automatic run_file();
    logic [7:0]       tag;
    logic [8*128-1:0] rest;
    logic [3:0]       cnt;
    logic [3:0]       pad;
    logic             sop;
    logic             eop;
    logic [1:0]       err;
    logic [2:0]       tc;
    logic [2:0]       pos;
    logic [15:0]      ts;
    logic [63:0]      base;
    int               code;
    bit               open;
    bit               more;
    bit               got;
    open = 1'b0;
    more = 1'b1;
    while (more) begin
      code = $fscanf(fd, "%s", tag);
      if (code != 1) begin
        more = 1'b0;
      end else if (tag == "#") begin
        code = $fgets(rest, fd);
      end else if (tag == "T") begin
        if (open) begin
          end_test();
        end
        code = $fscanf(fd, "%s", test_name);
        open = 1'b1;
        test_errs = 0;
      end else if (tag == "B") begin
        code = $fscanf(fd, "%h %h %h %h %h %h %h", cnt, sop, eop, err, tc, ts, base);
        drive_beat(cnt, sop, eop, err, tc, ts, base);
        // one idle beat must follow eop, up to two more give a random gap
        if (eop) begin
          drive_idle(1 + int'($urandom % 3));
        end
      end else if (tag == "E") begin
        code = $fscanf(fd, "%h %h %h %h %h %h %h %h", base, pos, sop, eop, err, tc, ts, pad);
        wait_segment(got);
        assert (got) else begin
          $display("%0s: no segment arrived within %0d cycles", test_name, seg_timeout);
          test_errs++;
          aborted = 1'b1;
        end
        if (got) begin
          check_segment(base, pos, sop, eop, err, tc, ts, pad);
        end
      end else begin
        $display("unknown record type %0s in the stimulus file", tag);
        aborted = 1'b1;
      end
      if (aborted) begin
        more = 1'b0;
      end
    end
    if (open) begin
      end_test();
    end
  endtask

  initial begin
    rst       <= 1'b1;
    i_rx_data <= '0;
    i_rx_cnt  <= 4'd0;
    i_rx_sop  <= 1'b0;
    i_rx_eop  <= 1'b0;
    i_rx_err  <= 2'b00;
    i_rx_tc   <= 3'd0;
    i_rx_ts   <= 16'h0;
    aborted   = 1'b0;
    pass_cnt  = 0;
    fail_cnt  = 0;
    test_errs = 0;
    void'($urandom(32'hb872_02ab));
    repeat (8) @(posedge cclk);
    rst <= 1'b0;
    fd = $fopen("test/seg_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file test/seg_input.txt");
      aborted = 1'b1;
    end else begin
      run_file();
      $fclose(fd);
    end
    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (aborted || (fail_cnt != 0)) begin
      $display("Test failed");
    end else begin
      $display("Test completed successfully");
    end
    $finish;
  end

endmodule

/* test/seg_input.txt */
# B cnt sop eop err tc ts base : one beat in hex, word k is base+k with its low byte as check byte
# E first eop_pos sop eop err tc ts pad : one expected segment in hex, pad is the padded lane count
T reset_state
T aligned
B 8 1 0 0 1 1001 100
B 8 0 0 0 1 1002 108
B 8 0 1 0 1 1003 110
E 100 7 1 0 0 1 1001 0
E 108 7 0 0 0 1 1002 0
E 110 7 0 1 0 1 1003 0
T unaligned
B 3 1 0 0 2 2001 200
B 3 0 0 0 2 2002 203
B 5 0 0 0 2 2003 206
B 5 0 1 0 2 2004 20b
E 200 7 1 0 0 2 2001 0
E 208 7 0 1 0 2 2004 0
T partial_eop
B 5 1 0 0 3 3001 300
B 2 0 1 0 3 3002 305
E 300 6 1 1 0 3 3001 1
B 3 1 1 0 4 3101 310
E 310 2 1 1 0 4 3101 5
T sop_metadata
B 4 1 0 1 5 4001 400
B 4 0 1 2 6 4002 404
E 400 7 1 1 3 5 4001 0
T double_done
B 6 1 0 0 6 5001 500
B 5 0 1 0 6 5002 506
E 500 7 1 0 0 6 5001 0
E 508 2 0 1 0 6 5002 5
B 8 1 1 0 7 6001 600
E 600 7 1 1 0 7 6001 0

/* verilog.f */
verilog/igr_seg_pkg.sv
verilog/seg_wr_if.sv
verilog/seg_pack_ctrl.sv
verilog/shim_seg.sv
verilog/seg_out.sv
verilog/igr_seg_top.sv
test/tb_igr_seg.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator from the project root, run, and pass only on the pass message
verilator --binary --assert --top-module tb_igr_seg -o tb_igr_seg -f verilog.f &&
  ./obj_dir/tb_igr_seg | tee /dev/stderr | grep -q "Test completed successfully" &&
  echo "simulation PASS" ||
  { echo "simulation FAIL"; exit 1; }
